//--- design/avalon_bus_pkg.sv
// ----------------------------------------------------------
// avalon bus definitions
// widths and command structs for the universal command
// port and the fixed-timing slave side
// ----------------------------------------------------------

package avalon_bus_pkg;

   // ----------------------------------------------------------
   // universal side, byte addressed
   // ----------------------------------------------------------
   localparam int UAV_ADDR_W  = 32;
   localparam int UAV_BURST_W = 6;   // burst count in bytes

   localparam int DATA_W = 32;
   localparam int BE_W   = DATA_W / 8;

   // ----------------------------------------------------------
   // slave side, word addressed
   // ----------------------------------------------------------
   localparam int WORD_SHIFT = 2;                         // log2 bytes per word
   localparam int AV_ADDR_W  = UAV_ADDR_W - WORD_SHIFT;
   localparam int AV_BURST_W = UAV_BURST_W - WORD_SHIFT;

   typedef struct packed {
      logic                   read;
      logic                   write;
      logic [UAV_ADDR_W-1:0]  address;
      logic [UAV_BURST_W-1:0] burstcount;
      logic [BE_W-1:0]        byteenable;
      logic [DATA_W-1:0]      writedata;
   } uav_cmd_t;   // 76 bits

   typedef struct packed {
      logic [AV_ADDR_W-1:0]  address;
      logic [AV_BURST_W-1:0] burstcount;
      logic [BE_W-1:0]       byteenable;
      logic [BE_W-1:0]       writebyteenable;   // zero on reads
      logic [DATA_W-1:0]     writedata;
   } av_cmd_t;    // 74 bits

endpackage

//--- design/wait_timing_pkg.sv
// ----------------------------------------------------------
// wait state timing definitions
// counter type for the wait-state sequencer and the
// legal ranges of the timing parameters
// ----------------------------------------------------------

package wait_timing_pkg;

   localparam int WAIT_CNT_W = 4;

   // counts cycles of a held command, cycle 0 first
   typedef logic [WAIT_CNT_W-1:0] wait_count_t;

   // ----------------------------------------------------------
   // limits
   // ----------------------------------------------------------

   // setup + write wait + hold must fit in the counter
   localparam int MAX_WAIT_INDEX = (1 << WAIT_CNT_W) - 1;

   // depth of the read return pipeline
   localparam int MAX_READ_LATENCY = 8;

endpackage

//--- design/cmd_decode.sv
// ----------------------------------------------------------
// command decode
// maps the byte addressed universal command onto the word
// addressed slave command and follows write burst beats
// ----------------------------------------------------------

`timescale 1ns/1ps

module cmd_decode (
   input  logic                     clk,
   input  logic                     reset,
   input  avalon_bus_pkg::uav_cmd_t uav,
   input  logic                     accept,   // command taken this cycle
   output avalon_bus_pkg::av_cmd_t  av,
   output logic                     first_beat
);
   import avalon_bus_pkg::*;

   logic [AV_BURST_W-1:0] beats_left;   // beats still owed after this one
   logic                  write_beat;

   // ----------------------------------------------------------
   // address, burst count and lanes
   // ----------------------------------------------------------
   always_comb begin
      av.address    = uav.address[UAV_ADDR_W-1:WORD_SHIFT];       // byte -> word
      av.burstcount = uav.burstcount[UAV_BURST_W-1:WORD_SHIFT];   // bytes -> words
      av.byteenable = uav.byteenable;
      av.writedata  = uav.writedata;

      // slave only sees write lanes during a write
      if (uav.write) begin
         av.writebyteenable = uav.byteenable;
      end else begin
         av.writebyteenable = '0;
      end
   end

   // ----------------------------------------------------------
   // write burst beat tracking
   // ----------------------------------------------------------
   assign write_beat = accept & uav.write;

   // zero means the next write starts a new burst
   assign first_beat = (beats_left == '0);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         beats_left <= '0;
      end else if (write_beat) begin
         if (first_beat) begin
            // single-beat burst leaves the counter at zero
            beats_left <= av.burstcount - 1'b1;
         end else begin
            beats_left <= beats_left - 1'b1;
         end
      end
   end

endmodule

//--- design/wait_state_sequencer.sv
// ----------------------------------------------------------
// wait state sequencer
// counts the cycles of a held command, releases waitrequest
// at the end of the read or hold window and drives the
// slave strobes and transfer start marks
// ----------------------------------------------------------

`timescale 1ns/1ps

module wait_state_sequencer #(
   parameter wait_timing_pkg::wait_count_t SETUP_CYCLES      = 1,
   parameter wait_timing_pkg::wait_count_t READ_WAIT_CYCLES  = 1,
   parameter wait_timing_pkg::wait_count_t WRITE_WAIT_CYCLES = 1,
   parameter wait_timing_pkg::wait_count_t HOLD_CYCLES       = 1
) (
   input  logic clk,
   input  logic reset,
   input  logic read,
   input  logic write,
   input  logic first_beat,           // next write beat opens a burst
   output logic waitrequest,
   output logic accept,
   output logic av_read,
   output logic av_write,
   output logic begintransfer,
   output logic beginbursttransfer
);
   import wait_timing_pkg::*;

   // cycle indices where each window ends
   localparam int R_IDX = int'(SETUP_CYCLES) + int'(READ_WAIT_CYCLES);
   localparam int W_IDX = int'(SETUP_CYCLES) + int'(WRITE_WAIT_CYCLES);
   localparam int H_IDX = W_IDX + int'(HOLD_CYCLES);

   if (R_IDX > MAX_WAIT_INDEX || H_IDX > MAX_WAIT_INDEX) begin : g_bad_timing
      $error("wait_state_sequencer: timing does not fit the wait counter");
   end

   wait_count_t wait_cnt;
   logic        reset_override;   // holds off the first cycle after reset
   logic        begin_done;       // cycle 0 of this command has passed
   logic        active;
   logic        window_end;

   assign active = (read | write) & ~reset_override;

   // ----------------------------------------------------------
   // wait counter
   // ----------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt       <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         if (!waitrequest || reset_override) begin
            wait_cnt <= '0;                  // restart for the next command
         end else if (read || write) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0;
         end
      end
   end

   // writes also wait out the hold cycles
   assign window_end = write ? (wait_cnt == wait_count_t'(H_IDX))
                             : (wait_cnt == wait_count_t'(R_IDX));

   assign waitrequest = reset_override | ~window_end;
   assign accept      = (read | write) & ~waitrequest;

   // ----------------------------------------------------------
   // strobes
   // ----------------------------------------------------------
   assign av_read  = active & read & (wait_cnt >= SETUP_CYCLES);
   assign av_write = active & write & (wait_cnt >= SETUP_CYCLES)
                   & (wait_cnt <= wait_count_t'(W_IDX));   // low again in hold

   // ----------------------------------------------------------
   // begin marks
   // ----------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         begin_done <= 1'b0;
      end else if (!waitrequest) begin
         begin_done <= 1'b0;
      end else if (begintransfer) begin
         begin_done <= 1'b1;
      end
   end

   assign begintransfer      = active & ~begin_done;
   assign beginbursttransfer = begintransfer & (read | first_beat);   // every read

endmodule

//--- design/read_return.sv
// ----------------------------------------------------------
// read return
// fixed latency pipeline marking when slave read data is
// valid, several reads may be in flight
// ----------------------------------------------------------

`timescale 1ns/1ps

module read_return #(
   parameter int unsigned READ_LATENCY = 1
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              read_accept,
   input  logic [avalon_bus_pkg::DATA_W-1:0] av_readdata,
   output logic                              readdatavalid,
   output logic [avalon_bus_pkg::DATA_W-1:0] readdata
);
   import wait_timing_pkg::*;

   if (READ_LATENCY < 1 || READ_LATENCY > MAX_READ_LATENCY) begin : g_bad_latency
      $error("read_return: READ_LATENCY out of range");
   end

   // one bit per cycle since acceptance
   logic [READ_LATENCY-1:0] in_flight;

   // ----------------------------------------------------------
   // latency shift register
   // ----------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_flight <= '0;
      end else begin
         in_flight[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            in_flight[i] <= in_flight[i-1];
         end
      end
   end

   assign readdatavalid = in_flight[READ_LATENCY-1];

   // slave drives its data in the valid cycle
   assign readdata = readdatavalid ? av_readdata : '0;

endmodule

//--- design/fixed_slave_adapter.sv
// ----------------------------------------------------------
// fixed slave adapter
// universal avalon command port to a slave with fixed read
// and write timing and fixed read latency
// ----------------------------------------------------------

`timescale 1ns/1ps

module fixed_slave_adapter #(
   parameter int unsigned                  READ_LATENCY      = 2,
   parameter wait_timing_pkg::wait_count_t SETUP_CYCLES      = 1,
   parameter wait_timing_pkg::wait_count_t READ_WAIT_CYCLES  = 2,
   parameter wait_timing_pkg::wait_count_t WRITE_WAIT_CYCLES = 1,
   parameter wait_timing_pkg::wait_count_t HOLD_CYCLES       = 1
) (
   input  logic                              clk,
   input  logic                              reset,

   // universal command port
   input  avalon_bus_pkg::uav_cmd_t          uav,
   output logic                              uav_waitrequest,
   output logic                              uav_readdatavalid,
   output logic [avalon_bus_pkg::DATA_W-1:0] uav_readdata,

   // fixed timing slave
   output avalon_bus_pkg::av_cmd_t           av,
   output logic                              av_read,
   output logic                              av_write,
   output logic                              av_begintransfer,
   output logic                              av_beginbursttransfer,
   input  logic [avalon_bus_pkg::DATA_W-1:0] av_readdata
);

   logic accept;
   logic first_beat;
   logic read_accept;

   assign read_accept = accept & uav.read;

   // ----------------------------------------------------------
   // decode
   // ----------------------------------------------------------
   cmd_decode decode_i (
      .clk        (clk),
      .reset      (reset),
      .uav        (uav),
      .accept     (accept),
      .av         (av),
      .first_beat (first_beat)
   );

   // ----------------------------------------------------------
   // wait states
   // ----------------------------------------------------------
   wait_state_sequencer #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES)
   ) sequencer_i (
      .clk                (clk),
      .reset              (reset),
      .read               (uav.read),
      .write              (uav.write),
      .first_beat         (first_beat),
      .waitrequest        (uav_waitrequest),
      .accept             (accept),
      .av_read            (av_read),
      .av_write           (av_write),
      .begintransfer      (av_begintransfer),
      .beginbursttransfer (av_beginbursttransfer)
   );

   // ----------------------------------------------------------
   // read data return
   // ----------------------------------------------------------
   read_return #(
      .READ_LATENCY (READ_LATENCY)
   ) return_i (
      .clk           (clk),
      .reset         (reset),
      .read_accept   (read_accept),
      .av_readdata   (av_readdata),
      .readdatavalid (uav_readdatavalid),
      .readdata      (uav_readdata)
   );

endmodule

//--- bench/wait_state_assertions.sv
// ----------------------------------------------------------
// wait state sequencer checks
// strobe exclusion, single cycle begin marks, reset release
// and hold cycle behavior of every sequencer instance
// ----------------------------------------------------------

`timescale 1ns/1ps

module wait_state_assertions #(
   parameter int HOLD = 1
) (
   input logic clk,
   input logic reset,
   input logic write,
   input logic waitrequest,
   input logic av_read,
   input logic av_write,
   input logic begintransfer
);

   int fail_count = 0;   // failed assertions so far

   strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(av_read && av_write))
      else begin
         fail_count++;
         $error("av_read and av_write high together");
      end

   begin_one_cycle: assert property (@(posedge clk) disable iff (reset)
      begintransfer |=> !begintransfer)
      else begin
         fail_count++;
         $error("begintransfer held for more than one cycle");
      end

   wait_after_reset: assert property (@(posedge clk) $fell(reset) |-> waitrequest)
      else begin
         fail_count++;
         $error("waitrequest low in first cycle after reset");
      end

   // a write is accepted in its last hold cycle
   no_write_in_hold: assert property (@(posedge clk) disable iff (reset)
      (HOLD > 0) && write && !waitrequest |-> !av_write)
      else begin
         fail_count++;
         $error("av_write high during a hold cycle");
      end

endmodule

bind wait_state_sequencer wait_state_assertions #(
   .HOLD (int'(HOLD_CYCLES))
) wsa_i (
   .clk           (clk),
   .reset         (reset),
   .write         (write),
   .waitrequest   (waitrequest),
   .av_read       (av_read),
   .av_write      (av_write),
   .begintransfer (begintransfer)
);

//--- bench/tb_fixed_slave_adapter.sv
// ----------------------------------------------------------
// fixed slave adapter testbench
// directed tests against a 64 word slave memory model,
// with a monitor for read data return timing
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_fixed_slave_adapter;
   import avalon_bus_pkg::*;
   import wait_timing_pkg::*;

   localparam int unsigned READ_LATENCY = 2;
   localparam int SETUP_CYC      = 1;
   localparam int READ_WAIT_CYC  = 2;
   localparam int WRITE_WAIT_CYC = 1;
   localparam int HOLD_CYC       = 1;
   localparam int R_CYC = SETUP_CYC + READ_WAIT_CYC;    // read accept cycle
   localparam int W_CYC = SETUP_CYC + WRITE_WAIT_CYC;   // last av_write cycle
   localparam int H_CYC = W_CYC + HOLD_CYC;             // write accept cycle

   localparam int MEM_WORDS  = 64;
   localparam int MAX_CYC    = 15;
   localparam int CLK_NS     = 4;
   localparam int COMMANDS   = 25;
   localparam int RUN_CYCLES = 3 + COMMANDS * (H_CYC + 1) + 5 * (READ_LATENCY + 4);
   localparam int TIMEOUT_NS = RUN_CYCLES * CLK_NS + 200;

   // what the master sees in one cycle of a held command
   typedef struct packed {
      logic waitreq;
      logic rd;
      logic wr;
      logic bt;
      logic bbt;
      logic rdv;
   } cycle_obs_t;

   logic              clk;
   logic              reset;
   uav_cmd_t          uav;
   logic              uav_waitrequest;
   logic              uav_readdatavalid;
   logic [DATA_W-1:0] uav_readdata;
   av_cmd_t           av;
   logic              av_read;
   logic              av_write;
   logic              av_begintransfer;
   logic              av_beginbursttransfer;
   logic [DATA_W-1:0] av_readdata;

   int                    seed = 89;
   int                    cycle_no = 0;
   cycle_obs_t            trace [MAX_CYC+1];
   logic [AV_ADDR_W-1:0]  first_addr;
   logic [AV_BURST_W-1:0] first_burst;
   logic [BE_W-1:0]       first_be;
   logic [BE_W-1:0]       first_wbe;
   logic [DATA_W-1:0]     ref_mem [MEM_WORDS];   // expected contents
   int                    due_q [$];             // cycle each read must return
   logic [DATA_W-1:0]     exp_q [$];

   // slave memory model
   logic [DATA_W-1:0]       mem [MEM_WORDS];
   logic [5:0]              rd_addr [READ_LATENCY];
   logic [READ_LATENCY-1:0] rd_due;

   fixed_slave_adapter #(
      .READ_LATENCY      (READ_LATENCY),
      .SETUP_CYCLES      (wait_count_t'(SETUP_CYC)),
      .READ_WAIT_CYCLES  (wait_count_t'(READ_WAIT_CYC)),
      .WRITE_WAIT_CYCLES (wait_count_t'(WRITE_WAIT_CYC)),
      .HOLD_CYCLES       (wait_count_t'(HOLD_CYC))
   ) dut_i (
      .clk                   (clk),
      .reset                 (reset),
      .uav                   (uav),
      .uav_waitrequest       (uav_waitrequest),
      .uav_readdatavalid     (uav_readdatavalid),
      .uav_readdata          (uav_readdata),
      .av                    (av),
      .av_read               (av_read),
      .av_write              (av_write),
      .av_begintransfer      (av_begintransfer),
      .av_beginbursttransfer (av_beginbursttransfer),
      .av_readdata           (av_readdata)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   always @(posedge clk) cycle_no <= cycle_no + 1;

   initial begin
      #(TIMEOUT_NS);
      report_failure("timeout, tests did not finish in the expected time");
   end

   // ----------------------------------------------------------
   // checking
   // ----------------------------------------------------------
   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      abort_run();
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
         abort_run();
      end
   endtask

   function automatic logic [DATA_W-1:0] fill_word(input int word);
      logic [5:0] a;
      a = word[5:0];
      return {8'hc3, 2'b01, a, 2'b10, ~a, 8'h5e};
   endfunction

   // ----------------------------------------------------------
   // slave memory model and read data monitor
   // ----------------------------------------------------------
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= fill_word(i);
         end
         rd_due <= '0;
      end else begin
         for (int b = 0; b < BE_W; b++) begin
            if (av_write && av.writebyteenable[b]) begin
               mem[av.address[5:0]][8*b +: 8] <= av.writedata[8*b +: 8];
            end
         end
         rd_due[0]  <= uav.read & ~uav_waitrequest;   // read accepted
         rd_addr[0] <= av.address[5:0];
         for (int i = 1; i < READ_LATENCY; i++) begin
            rd_due[i]  <= rd_due[i-1];
            rd_addr[i] <= rd_addr[i-1];
         end
      end
   end

   assign av_readdata = rd_due[READ_LATENCY-1] ? mem[rd_addr[READ_LATENCY-1]] : '0;

   always @(negedge clk) begin
      if (due_q.size() > 0 && due_q[0] == cycle_no) begin
         check_value("uav_readdatavalid", uav_readdatavalid, 1'b1);
         check_value("uav_readdata", uav_readdata, exp_q[0]);
         void'(due_q.pop_front());
         void'(exp_q.pop_front());
      end else if (uav_readdatavalid) begin
         report_failure("uav_readdatavalid high with no read due in this cycle");
      end
   end

   // ----------------------------------------------------------
   // command driving
   // ----------------------------------------------------------
   function automatic uav_cmd_t make_cmd(input logic rd, input logic wr, input int word,
                                         input int bytes, input logic [BE_W-1:0] be,
                                         input logic [DATA_W-1:0] data);
      uav_cmd_t cmd;
      cmd.read       = rd;
      cmd.write      = wr;
      cmd.address    = UAV_ADDR_W'(word) << WORD_SHIFT;
      cmd.burstcount = UAV_BURST_W'(bytes);
      cmd.byteenable = be;
      cmd.writedata  = data;
      return cmd;
   endfunction

   function automatic cycle_obs_t sample_cycle();
      return '{uav_waitrequest, av_read, av_write, av_begintransfer,
               av_beginbursttransfer, uav_readdatavalid};
   endfunction

   // holds cmd until accepted, accept_k is the accept cycle
   task automatic run_command(input uav_cmd_t cmd, output int accept_k);
      int k;
      k = 0;
      @(posedge clk);
      uav <= cmd;
      @(negedge clk);
      first_addr  = av.address;
      first_burst = av.burstcount;
      first_be    = av.byteenable;
      first_wbe   = av.writebyteenable;
      trace[0]    = sample_cycle();
      while (uav_waitrequest) begin
         if (k == MAX_CYC) begin
            report_failure("uav_waitrequest never dropped for a held command");
         end
         k++;
         @(negedge clk);
         trace[k] = sample_cycle();
      end
      accept_k = k;
      if (cmd.read) begin
         due_q.push_back(cycle_no + READ_LATENCY);
         exp_q.push_back(ref_mem[cmd.address[WORD_SHIFT +: 6]]);
      end
   endtask

   task automatic go_idle();
      @(posedge clk);
      uav <= '0;
   endtask

   task automatic drain_reads();
      int waited;
      waited = 0;
      while (due_q.size() > 0) begin
         if (waited > READ_LATENCY + 2) begin
            report_failure("read data did not return after its latency");
         end
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic merge_write(input int word, input logic [BE_W-1:0] be,
                              input logic [DATA_W-1:0] data);
      for (int b = 0; b < BE_W; b++) begin
         if (be[b]) begin
            ref_mem[word][8*b +: 8] = data[8*b +: 8];
         end
      end
   endtask

   // ----------------------------------------------------------
   // directed tests
   // ----------------------------------------------------------
   task automatic expect_quiet();
      check_value("uav_waitrequest", uav_waitrequest, 1'b1);
      check_value("av_read", av_read, 1'b0);
      check_value("av_write", av_write, 1'b0);
      check_value("av_begintransfer", av_begintransfer, 1'b0);
      check_value("av_beginbursttransfer", av_beginbursttransfer, 1'b0);
      check_value("uav_readdatavalid", uav_readdatavalid, 1'b0);
   endtask

   task automatic reset_state();
      int       n;
      int       word;
      uav_cmd_t cmd;
      word = $random(seed) & (MEM_WORDS - 1);
      cmd  = make_cmd(1'b1, 1'b0, word, 4, 4'hf, '0);
      @(posedge clk);
      uav <= cmd;   // read held through reset release
      repeat (2) begin
         @(negedge clk);
         expect_quiet();
      end
      @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      expect_quiet();   // first cycle after release
      run_command(cmd, n);
      check_value("uav_waitrequest low cycle", n, R_CYC);
      check_value("av_begintransfer", trace[0].bt, 1'b1);
      go_idle();
      drain_reads();
   endtask

   task automatic write_and_read_back();
      int                n;
      int                word;
      logic [BE_W-1:0]   be;
      logic [DATA_W-1:0] data;
      word = $random(seed) & (MEM_WORDS - 1);
      be   = $random(seed);
      data = $random(seed);
      run_command(make_cmd(1'b0, 1'b1, word, 4, be, data), n);
      check_value("uav_waitrequest low cycle", n, H_CYC);
      for (int k = 0; k <= n; k++) begin
         check_value("uav_waitrequest", trace[k].waitreq, k != H_CYC);
         check_value("av_write", trace[k].wr, k >= SETUP_CYC && k <= W_CYC);
      end
      check_value("av.address", first_addr, word);
      check_value("av.byteenable", first_be, be);
      check_value("av.writebyteenable", first_wbe, be);
      merge_write(word, be, data);
      go_idle();
      run_command(make_cmd(1'b1, 1'b0, word, 4, 4'hf, '0), n);
      go_idle();
      drain_reads();
   endtask

   task automatic read_timing();
      int n;
      int word;
      word = $random(seed) & (MEM_WORDS - 1);
      run_command(make_cmd(1'b1, 1'b0, word, 4, 4'hf, '0), n);
      check_value("uav_waitrequest low cycle", n, R_CYC);
      for (int k = 0; k <= n; k++) begin
         check_value("av_read", trace[k].rd, k >= SETUP_CYC && k <= R_CYC);
         check_value("av_write", trace[k].wr, 1'b0);
         check_value("av_begintransfer", trace[k].bt, k == 0);
         check_value("av_beginbursttransfer", trace[k].bbt, k == 0);
      end
      check_value("av.writebyteenable", first_wbe, '0);
      go_idle();
      drain_reads();
   endtask

   task automatic pipelined_reads();
      int n;
      int word;
      for (int i = 0; i < 5; i++) begin
         word = $random(seed) & (MEM_WORDS - 1);
         run_command(make_cmd(1'b1, 1'b0, word, 4, 4'hf, '0), n);
         check_value("uav_waitrequest low cycle", n, R_CYC);
         if (i > 0) begin
            // previous read returns while this one is held
            check_value("uav_readdatavalid", trace[READ_LATENCY-1].rdv, 1'b1);
            check_value("uav_waitrequest", trace[READ_LATENCY-1].waitreq, 1'b1);
         end
      end
      go_idle();
      drain_reads();
   endtask

   task automatic write_burst_marks();
      int                n;
      int                base;
      logic [DATA_W-1:0] data;
      base = $random(seed) & 31;
      // two bursts of four beats each
      for (int b = 0; b < 8; b++) begin
         data = $random(seed);
         run_command(make_cmd(1'b0, 1'b1, base + b, 16, 4'hf, data), n);
         check_value("av.burstcount", first_burst, 4);
         check_value("av_begintransfer", trace[0].bt, 1'b1);
         check_value("av_beginbursttransfer", trace[0].bbt, (b % 4) == 0);
         for (int k = 1; k <= n; k++) begin
            check_value("av_begintransfer", trace[k].bt, 1'b0);
            check_value("av_beginbursttransfer", trace[k].bbt, 1'b0);
         end
         merge_write(base + b, 4'hf, data);
      end
      for (int b = 0; b < 8; b++) begin
         run_command(make_cmd(1'b1, 1'b0, base + b, 4, 4'hf, '0), n);
      end
      go_idle();
      drain_reads();
   endtask

   initial begin
      reset = 1'b1;
      uav   = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i] = fill_word(i);
      end
      reset_state();
      write_and_read_back();
      read_timing();
      pipelined_reads();
      write_burst_marks();
      repeat (2) @(posedge clk);
      if (dut_i.sequencer_i.wsa_i.fail_count != 0) begin
         report_failure("concurrent assertions in the sequencer failed");
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

//--- fixed_slave_adapter.f
design/avalon_bus_pkg.sv
design/wait_timing_pkg.sv
design/cmd_decode.sv
design/wait_state_sequencer.sv
design/read_return.sv
design/fixed_slave_adapter.sv
bench/wait_state_assertions.sv
bench/tb_fixed_slave_adapter.sv

//--- run.sh
#!/bin/sh
# build and run the fixed slave adapter testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
      --top-module tb_fixed_slave_adapter -f fixed_slave_adapter.f; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_fixed_slave_adapter 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1
